//--- tb.f
source/uart_pkg.sv
source/uart_config.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_rx_queue.sv
source/uart_top.sv
bench/uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = uart_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tb;
        import uart_pkg::*;

        localparam int num_frames = 13;
        localparam int max_div = 16;
        localparam int watchdog_ns = num_frames * 10 * max_div * 10 + 10000;

        logic clk;
        logic rst_n;
        logic cfg_wr;
        logic cfg_addr;
        cfg_word_u cfg_wdata;
        logic tx_start;
        logic [num_data_bits-1:0] tx_byte;
        logic rd;
        logic rx;
        logic tx;
        logic tx_busy;
        logic [num_data_bits-1:0] data;
        logic empty;
        logic overflow;
        logic frame_err;

        logic loop_sel;
        logic bench_rx;
        logic [31:0] lfsr;
        int errors;
        int ferr_count;
        int cur_div;
        logic [num_data_bits-1:0] model_q[$];

        // Receiver listens to its own transmitter or to the bench bit driver
        assign rx = loop_sel ? tx : bench_rx;

        uart_top uut (
                .clk       (clk),
                .rst_n     (rst_n),
                .cfg_wr    (cfg_wr),
                .cfg_addr  (cfg_addr),
                .cfg_wdata (cfg_wdata),
                .tx_start  (tx_start),
                .tx_byte   (tx_byte),
                .rd        (rd),
                .rx        (rx),
                .tx        (tx),
                .tx_busy   (tx_busy),
                .data      (data),
                .empty     (empty),
                .overflow  (overflow),
                .frame_err (frame_err)
        );

        always #5 clk = ~clk;

        // Right-shifting Galois LFSR with taps 32 22 2 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                logic [31:0] n;
                n = s >> 1;
                if (s[0])
                        n = n ^ 32'h8020_0003;
                return n;
        endfunction

        task automatic random_byte(output logic [num_data_bits-1:0] b);
                for (int i = 0; i < num_data_bits; i++)
                begin
                        lfsr = lfsr_next(lfsr);
                        b[i] = lfsr[0];
                end
        endtask

        task automatic check_value(input string name, input int expected, input int actual);
                assert (expected == actual)
                else
                begin
                        $display("Mismatch at %0t: %s expected %0h, got %0h",
                                 $time, name, expected, actual);
                        errors++;
                end
        endtask

        function automatic cfg_word_u ctrl_word(input logic rx_on, input logic tx_on,
                                                input logic clr);
                cfg_word_u w;
                w = '0;
                w.ctrl.rx_en = rx_on;
                w.ctrl.tx_en = tx_on;
                w.ctrl.clr_ovf = clr;
                return w;
        endfunction

        task automatic cfg_write(input logic addr, input cfg_word_u w);
                @(posedge clk);
                cfg_wr <= 1'b1;
                cfg_addr <= addr;
                cfg_wdata <= w;
                @(posedge clk);
                cfg_wr <= 1'b0;
                // Divisors under the minimum never take effect
                if (addr == cfg_addr_div && w.div >= div_min)
                        cur_div = w.div;
        endtask

        task automatic send_frame(input logic [num_data_bits-1:0] b, output int busy_cycles);
                busy_cycles = 0;
                @(negedge clk);
                check_value("tx_busy", 0, tx_busy);
                @(posedge clk);
                tx_start <= 1'b1;
                tx_byte <= b;
                @(posedge clk);
                tx_start <= 1'b0;
                tx_byte <= ~b;
                @(negedge clk);
                while (tx_busy && busy_cycles < 20 * max_div)
                begin
                        busy_cycles++;
                        @(negedge clk);
                end
        endtask

        task automatic loop_byte(input logic expect_rx);
                logic [num_data_bits-1:0] b;
                int busy;
                random_byte(b);
                send_frame(b, busy);
                check_value("tx_busy cycles", 10 * cur_div, busy);
                if (expect_rx)
                        model_q.push_back(b);
        endtask

        task automatic pop_byte();
                int guard;
                guard = 0;
                @(negedge clk);
                while (empty && guard < 4 * max_div)
                begin
                        guard++;
                        @(negedge clk);
                end
                if (empty)
                begin
                        $display("Queue stayed empty at %0t while a byte was due", $time);
                        errors++;
                end
                else
                begin
                        @(posedge clk);
                        rd <= 1'b1;
                        @(posedge clk);
                        rd <= 1'b0;
                end
        endtask

        task automatic drive_bit(input logic v);
                @(posedge clk);
                bench_rx <= v;
                repeat (cur_div - 1) @(posedge clk);
        endtask

        // Every honoured pop must show the oldest byte that was sent
        always @(posedge clk)
        begin
                if (rst_n && rd && !empty)
                begin
                        if (model_q.size() == 0)
                        begin
                                $display("Queue popped at %0t with no byte expected", $time);
                                errors++;
                        end
                        else
                        begin
                                check_value("data", model_q[0], data);
                                void'(model_q.pop_front());
                        end
                end
        end

        always @(posedge clk)
        begin
                if (rst_n && frame_err)
                        ferr_count++;
        end

        a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
                $rose(tx_busy) |-> $past(tx_start))
        else
        begin
                $display("tx_busy rose at %0t without a start strobe", $time);
                errors++;
        end

        a_idle_line: assert property (@(posedge clk) disable iff (!rst_n)
                !tx_busy |-> tx)
        else
        begin
                $display("tx low at %0t while the transmitter is idle", $time);
                errors++;
        end

        a_err_no_push: assert property (@(posedge clk) disable iff (!rst_n)
                frame_err |=> empty)
        else
        begin
                $display("Queue took a byte at %0t right after a framing error", $time);
                errors++;
        end

        initial
        begin
                #(watchdog_ns);
                $display("Watchdog expired at %0t before the tests finished", $time);
                $display("Errors: %0d", errors);
                $display("Result: FAILED");
                $finish;
        end

        initial
        begin
                logic [num_data_bits-1:0] b;
                int busy;
                int ferr_before;
                clk = 1'b0;
                rst_n = 1'b0;
                cfg_wr = 1'b0;
                cfg_addr = 1'b0;
                cfg_wdata = '0;
                tx_start = 1'b0;
                tx_byte = '0;
                rd = 1'b0;
                bench_rx = 1'b1;
                loop_sel = 1'b1;
                lfsr = 32'd81505;
                errors = 0;
                ferr_count = 0;
                cur_div = div_reset;
                repeat (3) @(posedge clk);
                rst_n <= 1'b1;

                @(negedge clk);
                check_value("tx", 1, tx);
                check_value("tx_busy", 0, tx_busy);
                check_value("empty", 1, empty);
                check_value("overflow", 0, overflow);
                check_value("frame_err", 0, frame_err);

                repeat (3)
                begin
                        loop_byte(1'b1);
                        pop_byte();
                end

                // Receiver off, the frame still goes out but nothing is queued
                cfg_write(cfg_addr_ctrl, ctrl_word(1'b0, 1'b1, 1'b0));
                loop_byte(1'b0);
                repeat (2 * cur_div) @(posedge clk);
                @(negedge clk);
                check_value("empty", 1, empty);
                cfg_write(cfg_addr_ctrl, ctrl_word(1'b1, 1'b0, 1'b0));
                random_byte(b);
                send_frame(b, busy);
                check_value("tx_busy cycles", 0, busy);
                check_value("tx", 1, tx);
                cfg_write(cfg_addr_ctrl, ctrl_word(1'b1, 1'b1, 1'b0));

                cfg_write(cfg_addr_div, 16'd8);
                loop_byte(1'b1);
                pop_byte();
                cfg_write(cfg_addr_div, 16'd2);
                loop_byte(1'b1);
                pop_byte();

                // Fifth byte finds the queue full and is dropped
                repeat (queue_depth + 1)
                        loop_byte(model_q.size() < queue_depth);
                repeat (cur_div) @(posedge clk);
                @(negedge clk);
                check_value("overflow", 1, overflow);
                repeat (queue_depth)
                        pop_byte();
                @(negedge clk);
                check_value("empty", 1, empty);
                check_value("overflow", 1, overflow);
                cfg_write(cfg_addr_ctrl, ctrl_word(1'b1, 1'b1, 1'b1));
                repeat (3) @(negedge clk);
                check_value("overflow", 0, overflow);
                loop_byte(1'b1);
                pop_byte();

                @(posedge clk);
                loop_sel <= 1'b0;
                ferr_before = ferr_count;
                random_byte(b);
                drive_bit(1'b0);
                for (int i = 0; i < num_data_bits; i++)
                        drive_bit(b[i]);
                drive_bit(1'b0);
                drive_bit(1'b1);
                repeat (2 * cur_div) @(posedge clk);
                @(negedge clk);
                check_value("frame_err pulses", 1, ferr_count - ferr_before);
                check_value("empty", 1, empty);

                repeat (5) @(posedge clk);
                $display("Errors: %0d, framing errors seen: %0d", errors, ferr_count);
                if (errors == 0)
                        $display("Result: PASSED");
                else
                        $display("Result: FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- source/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top (
        input wire logic clk,
        input wire logic rst_n,
        input wire logic cfg_wr,
        input wire logic cfg_addr,
        input wire uart_pkg::cfg_word_u cfg_wdata,
        input wire logic tx_start,
        input wire logic [uart_pkg::num_data_bits-1:0] tx_byte,
        input wire logic rd,
        input wire logic rx,
        output logic tx,
        output logic tx_busy,
        output logic [uart_pkg::num_data_bits-1:0] data,
        output logic empty,
        output logic overflow,
        output logic frame_err
);
        import uart_pkg::*;

        logic [div_width-1:0] baud_div;
        logic rx_en;
        logic tx_en;
        logic clr_ovf;
        logic [num_data_bits-1:0] rx_byte;
        logic rx_valid;

        uart_config u_config (
                .clk       (clk),
                .rst_n     (rst_n),
                .cfg_wr    (cfg_wr),
                .cfg_addr  (cfg_addr),
                .cfg_wdata (cfg_wdata),
                .baud_div  (baud_div),
                .rx_en     (rx_en),
                .tx_en     (tx_en),
                .clr_ovf   (clr_ovf)
        );

        uart_tx u_tx (
                .clk      (clk),
                .rst_n    (rst_n),
                .baud_div (baud_div),
                .tx_en    (tx_en),
                .tx_start (tx_start),
                .tx_byte  (tx_byte),
                .tx       (tx),
                .tx_busy  (tx_busy)
        );

        uart_rx u_rx (
                .clk       (clk),
                .rst_n     (rst_n),
                .baud_div  (baud_div),
                .rx_en     (rx_en),
                .rx        (rx),
                .rx_byte   (rx_byte),
                .rx_valid  (rx_valid),
                .frame_err (frame_err)
        );

        uart_rx_queue u_queue (
                .clk       (clk),
                .rst_n     (rst_n),
                .push      (rx_valid),
                .push_data (rx_byte),
                .rd        (rd),
                .clr_ovf   (clr_ovf),
                .data      (data),
                .empty     (empty),
                .overflow  (overflow)
        );

endmodule

`default_nettype wire

//--- source/uart_rx_queue.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_queue (
        input wire logic clk,
        input wire logic rst_n,
        input wire logic push,
        input wire logic [uart_pkg::num_data_bits-1:0] push_data,
        input wire logic rd,
        input wire logic clr_ovf,
        output logic [uart_pkg::num_data_bits-1:0] data,
        output logic empty,
        output logic overflow
);
        import uart_pkg::*;

        logic [num_data_bits-1:0] mem [queue_depth];
        logic [$clog2(queue_depth)-1:0] rd_ptr;
        logic [$clog2(queue_depth)-1:0] wr_ptr;
        logic [$clog2(queue_depth):0] count;
        logic full;
        logic do_pop;
        logic do_push;

        assign empty = (count == '0);
        assign full = (count == ($clog2(queue_depth) + 1)'(queue_depth));
        assign do_pop = rd && !empty;
        // A pop in the same cycle frees the slot for the incoming byte
        assign do_push = push && (!full || do_pop);
        assign data = mem[rd_ptr];

        always_ff @(posedge clk)
        begin
                if (do_push)
                        mem[wr_ptr] <= push_data;
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count <= '0;
                        overflow <= 1'b0;
                end
                else
                begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                        if (do_push && !do_pop)
                                count <= count + 1'b1;
                        else if (do_pop && !do_push)
                                count <= count - 1'b1;
                        if (push && !do_push)
                                overflow <= 1'b1;
                        else if (clr_ovf)
                                overflow <= 1'b0;
                end
        end

        a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
                count <= ($clog2(queue_depth) + 1)'(queue_depth))
                else $error("queue count %0d above depth", count);

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
        input wire logic clk,
        input wire logic rst_n,
        input wire logic [uart_pkg::div_width-1:0] baud_div,
        input wire logic rx_en,
        input wire logic rx,
        output logic [uart_pkg::num_data_bits-1:0] rx_byte,
        output logic rx_valid,
        output logic frame_err
);
        import uart_pkg::*;

        logic rx_meta;
        logic rx_sync;
        logic [2:0] state;
        logic [div_width-1:0] cnt;
        logic [$clog2(num_data_bits)-1:0] bit_cnt;
        logic half_end;
        logic bit_end;
        logic capture;

        // Two flops against metastability, idle line is high
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        rx_meta <= 1'b1;
                        rx_sync <= 1'b1;
                end
                else
                begin
                        rx_meta <= rx;
                        rx_sync <= rx_meta;
                end
        end

        assign half_end = (cnt >= (baud_div >> 1) - div_width'(1));
        assign bit_end = (cnt >= baud_div - div_width'(1));
        assign capture = rx_en && (state == rx_data_bit) && bit_end;

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state <= rx_standby;
                        cnt <= '0;
                        bit_cnt <= '0;
                        rx_valid <= 1'b0;
                        frame_err <= 1'b0;
                end
                else
                begin
                        rx_valid <= 1'b0;
                        frame_err <= 1'b0;
                        cnt <= cnt + 1'b1;
                        if (!rx_en)
                        begin
                                state <= rx_standby;
                                cnt <= '0;
                        end
                        else
                        begin
                                case (state)
                                rx_standby:
                                begin
                                        cnt <= '0;
                                        if (!rx_sync)
                                                state <= rx_half_start;
                                end
                                rx_half_start:
                                begin
                                        if (half_end)
                                        begin
                                                cnt <= '0;
                                                bit_cnt <= '0;
                                                // A high line at mid-start was only a glitch
                                                state <= rx_sync ? rx_standby : rx_data_bit;
                                        end
                                end
                                rx_data_bit:
                                begin
                                        if (bit_end)
                                        begin
                                                cnt <= '0;
                                                bit_cnt <= bit_cnt + 1'b1;
                                                if (bit_cnt == 3'(num_data_bits - 1))
                                                        state <= rx_stop_bit;
                                        end
                                end
                                rx_stop_bit:
                                begin
                                        if (bit_end)
                                        begin
                                                cnt <= '0;
                                                rx_valid <= rx_sync;
                                                frame_err <= !rx_sync;
                                                state <= rx_recover;
                                        end
                                end
                                default:
                                begin
                                        cnt <= '0;
                                        if (rx_sync)
                                                state <= rx_standby;
                                end
                                endcase
                        end
                end
        end

        // LSB arrives first, so bits enter at the top and move down
        always_ff @(posedge clk)
        begin
                if (capture)
                        rx_byte <= {rx_sync, rx_byte[num_data_bits-1:1]};
        end

        a_rx_excl: assert property (@(posedge clk) disable iff (!rst_n)
                !(rx_valid && frame_err))
                else $error("rx_valid and frame_err high together");

        a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                rx_valid |=> !rx_valid)
                else $error("rx_valid longer than one cycle");

        a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                frame_err |=> !frame_err)
                else $error("frame_err longer than one cycle");

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
        input wire logic clk,
        input wire logic rst_n,
        input wire logic [uart_pkg::div_width-1:0] baud_div,
        input wire logic tx_en,
        input wire logic tx_start,
        input wire logic [uart_pkg::num_data_bits-1:0] tx_byte,
        output logic tx,
        output logic tx_busy
);
        import uart_pkg::*;

        logic [1:0] state;
        logic [div_width-1:0] cnt;
        logic [$clog2(num_data_bits)-1:0] bit_cnt;
        logic [num_data_bits-1:0] shreg;
        logic bit_end;
        logic load;
        logic shift;
        logic last_bit;

        assign bit_end = (cnt >= baud_div - div_width'(1));
        assign load = (state == tx_idle) && tx_start && tx_en;
        assign shift = bit_end && ((state == tx_start_bit) || (state == tx_data_bit));
        assign last_bit = (bit_cnt == 3'(num_data_bits - 1));
        assign tx_busy = (state != tx_idle);

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state <= tx_idle;
                        cnt <= '0;
                        bit_cnt <= '0;
                        tx <= 1'b1;
                end
                else
                begin
                        cnt <= bit_end ? '0 : cnt + 1'b1;
                        case (state)
                        tx_idle:
                        begin
                                cnt <= '0;
                                tx <= 1'b1;
                                if (load)
                                begin
                                        tx <= 1'b0;
                                        state <= tx_start_bit;
                                end
                        end
                        tx_start_bit:
                        begin
                                if (bit_end)
                                begin
                                        tx <= shreg[0];
                                        bit_cnt <= '0;
                                        state <= tx_data_bit;
                                end
                        end
                        tx_data_bit:
                        begin
                                if (bit_end)
                                begin
                                        bit_cnt <= bit_cnt + 1'b1;
                                        tx <= last_bit ? 1'b1 : shreg[0];
                                        if (last_bit)
                                                state <= tx_stop_bit;
                                end
                        end
                        default:
                        begin
                                if (bit_end)
                                        state <= tx_idle;
                        end
                        endcase
                end
        end

        // Byte is held here so the host may change tx_byte during the frame
        always_ff @(posedge clk)
        begin
                if (load)
                        shreg <= tx_byte;
                else if (shift)
                        shreg <= shreg >> 1;
        end

        a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
                !tx_busy |-> tx)
                else $error("tx low while transmitter idle");

endmodule

`default_nettype wire

//--- source/uart_config.sv
`timescale 1ns/100ps
`default_nettype none

module uart_config (
        input wire logic clk,
        input wire logic rst_n,
        input wire logic cfg_wr,
        input wire logic cfg_addr,
        input wire uart_pkg::cfg_word_u cfg_wdata,
        output logic [uart_pkg::div_width-1:0] baud_div,
        output logic rx_en,
        output logic tx_en,
        output logic clr_ovf
);
        import uart_pkg::*;

        logic div_wr;
        logic ctrl_wr;
        logic div_ok;

        assign div_wr = cfg_wr && (cfg_addr == cfg_addr_div);
        assign ctrl_wr = cfg_wr && (cfg_addr == cfg_addr_ctrl);

        // A divisor below the minimum leaves too few cycles for mid-bit sampling
        assign div_ok = (cfg_wdata.div >= div_min);

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        baud_div <= div_reset;
                end
                else if (div_wr && div_ok)
                begin
                        baud_div <= cfg_wdata.div;
                end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        rx_en <= 1'b1;
                        tx_en <= 1'b1;
                end
                else if (ctrl_wr)
                begin
                        rx_en <= cfg_wdata.ctrl.rx_en;
                        tx_en <= cfg_wdata.ctrl.tx_en;
                end
        end

        // Clear pulse lasts exactly one cycle after the control write
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        clr_ovf <= 1'b0;
                end
                else
                begin
                        clr_ovf <= ctrl_wr && cfg_wdata.ctrl.clr_ovf;
                end
        end

        a_div_min: assert property (@(posedge clk) disable iff (!rst_n)
                baud_div >= div_min)
                else $error("baud_div %0d below minimum", baud_div);

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
`default_nettype none

package uart_pkg;

        // Frame is fixed at 8N1
        localparam int num_data_bits = 8;

        localparam int div_width = 16;
        localparam logic [div_width-1:0] div_min = 16'd4;
        localparam logic [div_width-1:0] div_reset = 16'd16;

        localparam int queue_depth = 4;

        localparam logic cfg_addr_div = 1'b0;
        localparam logic cfg_addr_ctrl = 1'b1;

        localparam logic [1:0] tx_idle = 2'd0;
        localparam logic [1:0] tx_start_bit = 2'd1;
        localparam logic [1:0] tx_data_bit = 2'd2;
        localparam logic [1:0] tx_stop_bit = 2'd3;

        localparam logic [2:0] rx_standby = 3'd0;
        localparam logic [2:0] rx_half_start = 3'd1;
        localparam logic [2:0] rx_data_bit = 3'd2;
        localparam logic [2:0] rx_stop_bit = 3'd3;
        localparam logic [2:0] rx_recover = 3'd4;

        // One write word, read as a divisor or as control bits depending on the address
        typedef union packed {
                logic [div_width-1:0] div;
                struct packed {
                        logic [div_width-4:0] reserved;
                        logic clr_ovf;
                        logic tx_en;
                        logic rx_en;
                } ctrl;
        } cfg_word_u;

endpackage

`default_nettype wire
